//--- sources.f
seq_pkg.sv
seq_regfile.sv
seq_decode.sv
seq_alu.sv
seq_branch_eval.sv
seq_core.sv
tb_seq_core_asserts.sv
tb_seq_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_seq_core -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^=== PASS ===$'; then
	exit 0
fi
exit 1

//--- tb_seq_core.sv
/*
 * Testbench for the multi-cycle core with random ack delays of 0 to 3 cycles.
 * Stores go to 0x1000 and up. Preset load data sits at 0x1800.
 * The program ends in a branch-always to itself.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_seq_core import seq_pkg::*; ();

	logic clk_g;
	logic rst_i;
	logic imem_req_o;
	word_t imem_adr_o;
	logic imem_ack_i;
	word_t imem_dat_i;
	logic dmem_req_o;
	logic dmem_we_o;
	word_t dmem_adr_o;
	word_t dmem_dat_o;
	logic dmem_ack_i;
	word_t dmem_dat_i;

	word_t imem [1024];
	word_t dmem [4096];
	word_t exp_adr [$];
	word_t exp_dat [$];
	logic [31:0] lcg_state = 32'h28a745c6;
	int n_insn = 0;
	int store_idx = 0;
	int fetch_acks = 0;
	int i_wait = -1;
	int d_wait = -1;

	seq_core u_dut (.*);

	always #50 clk_g = ~clk_g;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t fill_word(input word_t adr);
		return (adr * 32'h2545f491) ^ 32'hc3a50f1e ^ {adr[15:0], adr[31:16]};
	endfunction

	function automatic word_t sext14(input logic [13:0] v);
		return {{18{v[13]}}, v};
	endfunction

	function automatic logic [5:0] rs(input logic sgn, input int num);
		return {sgn, 5'(num)};
	endfunction

	// Expected result of one ALU operation from the instruction-set rules
	function automatic word_t ref_op(input func_t f, input word_t a, input word_t b,
		input logic sa, input logic sb, input logic st);
		logic lg;
		word_t x;
		word_t y;
		word_t r;
		lg = (f == F_AND) || (f == F_OR) || (f == F_EOR);
		x = sa ? (lg ? ~a : -a) : a;
		y = sb ? (lg ? ~b : -b) : b;
		r = '0;
		case (f)
			F_ADD: r = x + y;
			F_AND: r = x & y;
			F_OR: r = x | y;
			F_EOR: r = x ^ y;
			F_SHL: r = x << y[4:0];
			F_SHR: r = x >> y[4:0];
			F_ASR: r = word_t'($signed(x) >>> y[4:0]);
			default: begin
				r[0] = (x == y);
				r[1] = ($signed(x) < $signed(y));
				r[2] = (x < y);
			end
		endcase
		if (st)
			r = (f == F_ADD) ? -r : (f == F_CMP) ? (r ^ 32'h7) : ~r;
		return r;
	endfunction

	function automatic logic ref_take(input int c, input word_t a, input word_t b);
		case (c)
			0: return a == b;
			1: return a != b;
			2: return $signed(a) < $signed(b);
			3: return $signed(a) >= $signed(b);
			4: return a < b;
			5: return a >= b;
			default: return 1'b1;
		endcase
	endfunction

	task automatic emit(input word_t w);
		imem[n_insn] = w;
		n_insn++;
	endtask

	// Store of register rnum to the next result slot
	task automatic emit_store(input int rnum, output word_t adr);
		adr = 32'h1000 + 32'(4 * store_idx);
		store_idx++;
		emit({OP_STW, rs(0, rnum), rs(0, 0), adr[13:0]});
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input word_t got, input word_t expv);
		fail_now($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, expv));
	endtask

	// ====================
	// Memory models
	// ====================
	always @(posedge clk_g) begin : imem_model
		logic in_rst;
		in_rst = rst_i;
		#1;
		imem_ack_i = 1'b0;
		if (in_rst)
			i_wait = -1;
		else if (imem_req_o) begin
			if (i_wait < 0)
				i_wait = int'(lcg_next() >> 30);
			if (i_wait == 0) begin
				imem_ack_i = 1'b1;
				imem_dat_i = imem[imem_adr_o[11:2]];
				i_wait = -1;
			end else
				i_wait--;
		end
	end

	always @(posedge clk_g) begin : dmem_model
		logic in_rst;
		in_rst = rst_i;
		#1;
		dmem_ack_i = 1'b0;
		if (in_rst)
			d_wait = -1;
		else if (dmem_req_o) begin
			if (d_wait < 0)
				d_wait = int'(lcg_next() >> 30);
			if (d_wait == 0) begin
				dmem_ack_i = 1'b1;
				if (dmem_we_o)
					dmem[dmem_adr_o[13:2]] = dmem_dat_o;
				else
					dmem_dat_i = dmem[dmem_adr_o[13:2]];
				d_wait = -1;
			end else
				d_wait--;
		end
	end

	// ====================
	// Checker
	// ====================
	always @(negedge clk_g) begin
		if (!rst_i) begin
			if (imem_req_o && imem_ack_i)
				fetch_acks++;
			if (fetch_acks < 2) begin
				assert (!dmem_req_o)
				else fail_now("Data request seen before the first instruction completed");
			end
			if (dmem_req_o && dmem_ack_i && dmem_we_o) begin
				assert (exp_adr.size() != 0)
				else fail_now("Store seen after all expected stores were done");
				assert (dmem_adr_o == exp_adr[0])
				else fail_value("dmem_adr_o", dmem_adr_o, exp_adr[0]);
				assert (dmem_dat_o == exp_dat[0])
				else fail_value("dmem_dat_o", dmem_dat_o, exp_dat[0]);
				void'(exp_adr.pop_front());
				void'(exp_dat.pop_front());
			end
		end
	end

	initial begin
		@(negedge rst_i);
		repeat (n_insn * 20) @(posedge clk_g);
		fail_now("Timeout, the expected stores did not all arrive");
	end

	initial begin
		logic [13:0] ia;
		logic [13:0] ib;
		logic sa;
		logic sb;
		logic st;
		func_t f;
		word_t adr;
		word_t adr2;
		opcode_t iop [4];
		func_t ifn [4];

		clk_g = 1'b0;
		rst_i = 1'b1;
		imem_ack_i = 1'b0;
		imem_dat_i = '0;
		dmem_ack_i = 1'b0;
		dmem_dat_i = '0;
		iop = '{OP_ADDI, OP_ANDI, OP_ORI, OP_EORI};
		ifn = '{F_ADD, F_AND, F_OR, F_EOR};
		for (int i = 0; i < 4096; i++)
			dmem[i] = fill_word(32'(i) << 2);
		for (int i = 0; i < 1024; i++)
			imem[i] = '0;

		// Marker register r7
		emit({OP_ADDI, rs(0, 7), rs(0, 0), 14'h0077});
		// Register-form operations with random signs after the first plain pass
		for (int k = 0; k < 24; k++) begin
			f = func_t'(k % 8);
			ia = lcg_next() >> 18;
			ib = lcg_next() >> 18;
			sa = (k >= 8) && (lcg_next() >> 31);
			sb = (k >= 8) && (lcg_next() >> 31);
			st = (k >= 8) && (lcg_next() >> 31);
			emit({OP_ADDI, rs(0, 1), rs(0, 0), ia});
			emit({OP_ADDI, rs(0, 2), rs(0, 0), ib});
			emit({OP_R2, f, rs(st, 3), rs(sa, 1), rs(sb, 2), 3'b000});
			emit_store(3, adr);
			exp_adr.push_back(adr);
			exp_dat.push_back(ref_op(f, sext14(ia), sext14(ib), sa, sb, st));
		end
		// Immediate forms with sign flags on Ra and Rt
		for (int k = 0; k < 8; k++) begin
			ia = lcg_next() >> 18;
			ib = lcg_next() >> 18;
			sa = k[1];
			st = k[2] ^ k[0];
			emit({OP_ADDI, rs(0, 1), rs(0, 0), ia});
			emit({iop[k % 4], rs(st, 4), rs(sa, 1), ib});
			emit_store(4, adr);
			exp_adr.push_back(adr);
			exp_dat.push_back(ref_op(ifn[k % 4], sext14(ia), sext14(ib), sa, 1'b0, st));
		end
		// Loads from preset data plus an added amount
		for (int j = 0; j < 2; j++) begin
			adr2 = 32'h1800 + 32'(4 * j);
			ib = lcg_next() >> 18;
			emit({OP_LDW, rs(0, 5), rs(0, 0), adr2[13:0]});
			emit({OP_ADDI, rs(0, 6), rs(0, 5), ib});
			emit_store(6, adr);
			exp_adr.push_back(adr);
			exp_dat.push_back(fill_word(adr2) + sext14(ib));
		end
		// Branches over a marker store with equal, greater and smaller operands
		for (int c = 0; c < 7; c++) begin
			for (int t = 0; t < 3; t++) begin
				ia = (14'(lcg_next() >> 19) & 14'h1fff) ^ 14'h1000;
				ib = (t == 0) ? ia : (t == 1) ? ia + 14'(1 + (lcg_next() >> 26))
					: ia - 14'(1 + (lcg_next() >> 26));
				emit({OP_ADDI, rs(0, 1), rs(0, 0), ia});
				emit({OP_ADDI, rs(0, 2), rs(0, 0), ib});
				emit({OP_BCC, cond_t'(c), 5'd1, 5'd2, 13'd2});
				emit_store(7, adr);
				emit_store(7, adr2);
				if (!ref_take(c, sext14(ia), sext14(ib))) begin
					exp_adr.push_back(adr);
					exp_dat.push_back(32'h77);
				end
				exp_adr.push_back(adr2);
				exp_dat.push_back(32'h77);
			end
		end
		emit({OP_BCC, C_RA, 5'd0, 5'd0, 13'd0});

		repeat (3) @(posedge clk_g);
		#1 rst_i = 1'b0;
		@(negedge clk_g);
		assert (imem_req_o && !dmem_req_o)
		else fail_now("Fetch request missing or data request present after reset");
		assert (imem_adr_o == RESET_PC)
		else fail_value("imem_adr_o", imem_adr_o, RESET_PC);

		while (exp_adr.size() != 0)
			@(posedge clk_g);
		repeat (4) @(posedge clk_g);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_seq_core_asserts.sv
/*
 * Handshake assertions, bound into every seq_core instance.
 * Checks are off while reset is high.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_seq_core_asserts import seq_pkg::*; (
	input wire logic   clk_g,
	input wire logic   rst_i,
	input wire logic   imem_req_i,
	input wire word_t  imem_adr_i,
	input wire logic   imem_ack_i,
	input wire logic   dmem_req_i,
	input wire logic   dmem_we_i,
	input wire word_t  dmem_adr_i,
	input wire logic   dmem_ack_i
);

	// A request holds with a stable address until acked
	a_imem_hold: assert property (@(posedge clk_g) disable iff (rst_i)
		imem_req_i && !imem_ack_i |=> imem_req_i && $stable(imem_adr_i))
		else $error("fetch request dropped or address changed before ack");

	a_dmem_hold: assert property (@(posedge clk_g) disable iff (rst_i)
		dmem_req_i && !dmem_ack_i |=> dmem_req_i && $stable(dmem_adr_i) && $stable(dmem_we_i))
		else $error("data request dropped or changed before ack");

	a_we_req: assert property (@(posedge clk_g) disable iff (rst_i)
		dmem_we_i |-> dmem_req_i)
		else $error("write enable without data request");

	a_one_port: assert property (@(posedge clk_g) disable iff (rst_i)
		!(imem_req_i && dmem_req_i))
		else $error("fetch and data requests high together");

endmodule

bind seq_core tb_seq_core_asserts u_asserts (
	.clk_g      (clk_g),
	.rst_i      (rst_i),
	.imem_req_i (imem_req_o),
	.imem_adr_i (imem_adr_o),
	.imem_ack_i (imem_ack_i),
	.dmem_req_i (dmem_req_o),
	.dmem_we_i  (dmem_we_o),
	.dmem_adr_i (dmem_adr_o),
	.dmem_ack_i (dmem_ack_i)
);

`default_nettype wire

//--- seq_core.sv
/*
 * Multi-cycle scalar core, one instruction in flight at a time.
 * Both ports hold req with stable address until a one-cycle ack.
 * Word accesses only, the low address bits are not checked.
 * A load ignores the sign flag on its target register.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_core import seq_pkg::*; (
	input  logic  clk_g,
	input  logic  rst_i,
	output logic  imem_req_o,
	output word_t imem_adr_o,
	input  logic  imem_ack_i,
	input  word_t imem_dat_i,
	output logic  dmem_req_o,
	output logic  dmem_we_o,
	output word_t dmem_adr_o,
	output word_t dmem_dat_o,
	input  logic  dmem_ack_i,
	input  word_t dmem_dat_i
);

	state_t state;
	word_t pc;
	word_t opc;
	insn_u ir;
	word_t a;
	word_t b;
	word_t c;
	word_t ea;

	regspec_t ra;
	regspec_t rb;
	regspec_t rt;
	word_t imm;
	alu_op_t alu_op;
	logic use_imm;
	logic is_branch;
	logic is_load;
	logic is_store;
	logic wr_en;
	logic is_logic;

	word_t rd0;
	word_t rd1;
	word_t alu_res;
	word_t rf_wd;
	logic rf_we;
	logic take;

	// Source modifier: complement for logic ops, negate otherwise
	function automatic word_t apply_sign(input word_t v, input logic sgn, input logic cpl);
		if (!sgn)
			return v;
		return cpl ? ~v : -v;
	endfunction

	seq_decode u_decode (
		.insn_i      (ir),
		.ra_o        (ra),
		.rb_o        (rb),
		.rt_o        (rt),
		.imm_o       (imm),
		.alu_op_o    (alu_op),
		.use_imm_o   (use_imm),
		.is_branch_o (is_branch),
		.is_load_o   (is_load),
		.is_store_o  (is_store),
		.wr_en_o     (wr_en)
	);

	seq_regfile u_regfile (
		.clk_g (clk_g),
		.ra0_i (ra.num),
		.ra1_i (rb.num),
		.wa_i  (rt.num),
		.we_i  (rf_we),
		.wd_i  (rf_wd),
		.rd0_o (rd0),
		.rd1_o (rd1)
	);

	seq_alu u_alu (
		.a_i       (a),
		.b_i       (b),
		.op_i      (alu_op),
		.rt_sign_i (rt.sign),
		.res_o     (alu_res)
	);

	seq_branch_eval u_branch (
		.a_i    (a),
		.b_i    (b),
		.cond_i (ir.br.cnd),
		.take_o (take)
	);

	assign is_logic = (alu_op == ALU_AND) || (alu_op == ALU_OR) || (alu_op == ALU_EOR);

	// ALU results land at the end of EXECUTE, load data one cycle after ack
	assign rf_we = wr_en && (is_load ? (state == MEMWAIT) : (state == EXECUTE));
	assign rf_wd = is_load ? c : alu_res;

	// ====================
	// Sequencer
	// ====================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state <= IFETCH;
			pc <= RESET_PC;
		end else begin
			case (state)
				IFETCH: begin
					if (imem_ack_i) begin
						pc <= pc + word_t'(4);
						state <= DECODE;
					end
				end
				DECODE: state <= OFETCH;
				OFETCH: state <= EXECUTE;
				EXECUTE: begin
					if (is_branch && take)
						pc <= opc + imm;
					if (is_load || is_store)
						state <= MEMORY;
					else
						state <= IFETCH;
				end
				MEMORY: begin
					if (dmem_ack_i)
						state <= is_load ? MEMWAIT : IFETCH;
				end
				MEMWAIT: state <= IFETCH;
				default: state <= IFETCH;
			endcase
		end
	end

	// ====================
	// Datapath registers
	// ====================
	always_ff @(posedge clk_g) begin
		case (state)
			IFETCH: begin
				if (imem_ack_i) begin
					ir <= imem_dat_i;
					opc <= pc;
				end
			end
			OFETCH: begin
				a <= apply_sign(rd0, ra.sign, is_logic);
				if (use_imm)
					b <= imm;
				else
					b <= apply_sign(rd1, rb.sign, is_logic);
				// Store data comes through the rb port
				if (is_store)
					c <= apply_sign(rd1, rb.sign, 1'b0);
			end
			EXECUTE: ea <= a + b;
			MEMORY: begin
				if (dmem_ack_i && is_load)
					c <= dmem_dat_i;
			end
			default: ;
		endcase
	end

	assign imem_req_o = (state == IFETCH);
	assign imem_adr_o = pc;
	assign dmem_req_o = (state == MEMORY);
	assign dmem_we_o = (state == MEMORY) && is_store;
	assign dmem_adr_o = ea;
	assign dmem_dat_o = c;

endmodule

`default_nettype wire

//--- seq_branch_eval.sv
/*
 * Branch condition check on the two raw register operands.
 * Condition code 7 is unassigned and never takes.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_branch_eval import seq_pkg::*; (
	input  word_t a_i,
	input  word_t b_i,
	input  cond_t cond_i,
	output logic  take_o
);

	always_comb begin
		case (cond_i)
			C_EQ: take_o = (a_i == b_i);
			C_NE: take_o = (a_i != b_i);
			C_LT: take_o = ($signed(a_i) < $signed(b_i));
			C_GE: take_o = ($signed(a_i) >= $signed(b_i));
			C_LTU: take_o = (a_i < b_i);
			C_GEU: take_o = (a_i >= b_i);
			C_RA: take_o = 1'b1;
			default: take_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- seq_alu.sv
/*
 * Integer ALU, purely combinational.
 * Shift counts use the low 5 bits of b only.
 * rt_sign_i negates an add, complements logic and shift results
 * and inverts the three compare flags.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_alu import seq_pkg::*; (
	input  word_t   a_i,
	input  word_t   b_i,
	input  alu_op_t op_i,
	input  logic    rt_sign_i,
	output word_t   res_o
);

	word_t sum;
	word_t bits;
	logic [SHAMT_W-1:0] shamt;
	logic eq;
	logic lt;
	logic ltu;

	assign shamt = b_i[SHAMT_W-1:0];
	assign sum = a_i + b_i;
	assign eq = (a_i == b_i);
	assign lt = ($signed(a_i) < $signed(b_i));
	assign ltu = (a_i < b_i);

	// Logic and shift results before the target modifier
	always_comb begin
		case (op_i)
			ALU_AND: bits = a_i & b_i;
			ALU_OR: bits = a_i | b_i;
			ALU_EOR: bits = a_i ^ b_i;
			ALU_SHL: bits = a_i << shamt;
			ALU_SHR: bits = a_i >> shamt;
			ALU_ASR: bits = word_t'($signed(a_i) >>> shamt);
			default: bits = sum;
		endcase
	end

	always_comb begin
		res_o = '0;
		case (op_i)
			ALU_ADD: res_o = rt_sign_i ? -sum : sum;
			ALU_CMP: begin
				res_o[CMP_EQ_BIT] = eq ^ rt_sign_i;
				res_o[CMP_LT_BIT] = lt ^ rt_sign_i;
				res_o[CMP_LTU_BIT] = ltu ^ rt_sign_i;
			end
			default: res_o = rt_sign_i ? ~bits : bits;
		endcase
	end

endmodule

`default_nettype wire

//--- seq_decode.sv
/*
 * Combinational instruction decode.
 * Stores route the data register (ri.rt) onto the rb read port.
 * Branch register fields carry no sign flag.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_decode import seq_pkg::*; (
	input  insn_u    insn_i,
	output regspec_t ra_o,
	output regspec_t rb_o,
	output regspec_t rt_o,
	output word_t    imm_o,
	output alu_op_t  alu_op_o,
	output logic     use_imm_o,
	output logic     is_branch_o,
	output logic     is_load_o,
	output logic     is_store_o,
	output logic     wr_en_o
);

	always_comb begin
		ra_o = '0;
		rb_o = '0;
		rt_o = '0;
		imm_o = {{(XLEN-IMM_W){insn_i.ri.imm[IMM_W-1]}}, insn_i.ri.imm};
		alu_op_o = ALU_ADD;
		use_imm_o = 1'b0;
		is_branch_o = 1'b0;
		is_load_o = 1'b0;
		is_store_o = 1'b0;
		wr_en_o = 1'b0;
		case (insn_i.ri.opcode)
			OP_R2: begin
				ra_o = insn_i.r2.ra;
				rb_o = insn_i.r2.rb;
				rt_o = insn_i.r2.rt;
				wr_en_o = 1'b1;
				case (insn_i.r2.func)
					F_ADD: alu_op_o = ALU_ADD;
					F_AND: alu_op_o = ALU_AND;
					F_OR: alu_op_o = ALU_OR;
					F_EOR: alu_op_o = ALU_EOR;
					F_SHL: alu_op_o = ALU_SHL;
					F_SHR: alu_op_o = ALU_SHR;
					F_ASR: alu_op_o = ALU_ASR;
					F_CMP: alu_op_o = ALU_CMP;
					default: wr_en_o = 1'b0;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_EORI: begin
				ra_o = insn_i.ri.ra;
				rt_o = insn_i.ri.rt;
				use_imm_o = 1'b1;
				wr_en_o = 1'b1;
				if (insn_i.ri.opcode == OP_ANDI)
					alu_op_o = ALU_AND;
				else if (insn_i.ri.opcode == OP_ORI)
					alu_op_o = ALU_OR;
				else if (insn_i.ri.opcode == OP_EORI)
					alu_op_o = ALU_EOR;
			end
			OP_BCC: begin
				ra_o = '{sign: 1'b0, num: insn_i.br.ra};
				rb_o = '{sign: 1'b0, num: insn_i.br.rb};
				// Word displacement to byte offset
				imm_o = {{(XLEN-DISP_W-2){insn_i.br.disp[DISP_W-1]}}, insn_i.br.disp, 2'b00};
				is_branch_o = 1'b1;
			end
			OP_LDW: begin
				ra_o = insn_i.ri.ra;
				rt_o = insn_i.ri.rt;
				use_imm_o = 1'b1;
				is_load_o = 1'b1;
				wr_en_o = 1'b1;
			end
			OP_STW: begin
				ra_o = insn_i.ri.ra;
				rb_o = insn_i.ri.rt;
				rt_o = insn_i.ri.rt;
				use_imm_o = 1'b1;
				is_store_o = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- seq_regfile.sv
/*
 * 32 x 32-bit register file, two combinational reads, one write.
 * Register 0 reads as zero and ignores writes.
 * Contents are undefined after power-up.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_regfile import seq_pkg::*; (
	input  logic            clk_g,
	input  logic [REGW-1:0] ra0_i,
	input  logic [REGW-1:0] ra1_i,
	input  logic [REGW-1:0] wa_i,
	input  logic            we_i,
	input  word_t           wd_i,
	output word_t           rd0_o,
	output word_t           rd1_o
);

	word_t regs [NREGS];

	always_ff @(posedge clk_g) begin
		if (we_i && wa_i != '0)
			regs[wa_i] <= wd_i;
	end

	// Write-before-read is not forwarded, the sequencer never needs it
	assign rd0_o = (ra0_i == '0) ? '0 : regs[ra0_i];
	assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];

endmodule

`default_nettype wire

//--- seq_pkg.sv
/*
 * Shared types and constants for the multi-cycle scalar core.
 * All instructions are one 32-bit word in one of three views.
 * Opcode, function and condition codes outside the listed values
 * decode as a no-op.
 */
`default_nettype none

package seq_pkg;

	// ====================
	// Widths and constants
	// ====================
	localparam int XLEN = 32;
	localparam int NREGS = 32;
	localparam int REGW = $clog2(NREGS);
	localparam int SHAMT_W = $clog2(XLEN);
	localparam int IMM_W = 14;
	localparam int DISP_W = 13;

	typedef logic [XLEN-1:0] word_t;

	localparam word_t RESET_PC = '0;

	// Bit positions in a CMP result, all other bits are zero
	localparam int CMP_EQ_BIT = 0;
	localparam int CMP_LT_BIT = 1;
	localparam int CMP_LTU_BIT = 2;

	// ====================
	// Instruction fields
	// ====================
	typedef struct packed {
		logic sign;
		logic [REGW-1:0] num;
	} regspec_t;

	typedef enum logic [5:0] {
		OP_R2 = 6'd0,
		OP_ADDI = 6'd1,
		OP_ANDI = 6'd2,
		OP_ORI = 6'd3,
		OP_EORI = 6'd4,
		OP_BCC = 6'd5,
		OP_LDW = 6'd6,
		OP_STW = 6'd7
	} opcode_t;

	typedef enum logic [4:0] {
		F_ADD = 5'd0,
		F_AND = 5'd1,
		F_OR = 5'd2,
		F_EOR = 5'd3,
		F_SHL = 5'd4,
		F_SHR = 5'd5,
		F_ASR = 5'd6,
		F_CMP = 5'd7
	} func_t;

	// C_RA is branch always
	typedef enum logic [2:0] {
		C_EQ = 3'd0,
		C_NE = 3'd1,
		C_LT = 3'd2,
		C_GE = 3'd3,
		C_LTU = 3'd4,
		C_GEU = 3'd5,
		C_RA = 3'd6
	} cond_t;

	// Register form: spare bits are ignored
	typedef struct packed {
		opcode_t opcode;
		func_t func;
		regspec_t rt;
		regspec_t ra;
		regspec_t rb;
		logic [2:0] spare;
	} insn_r2_t;

	// Immediate form, also loads and stores with a byte offset
	typedef struct packed {
		opcode_t opcode;
		regspec_t rt;
		regspec_t ra;
		logic [IMM_W-1:0] imm;
	} insn_ri_t;

	// Branch form, displacement counts words
	typedef struct packed {
		opcode_t opcode;
		cond_t cnd;
		logic [REGW-1:0] ra;
		logic [REGW-1:0] rb;
		logic [DISP_W-1:0] disp;
	} insn_br_t;

	typedef union packed {
		insn_r2_t r2;
		insn_ri_t ri;
		insn_br_t br;
	} insn_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_SHL,
		ALU_SHR,
		ALU_ASR,
		ALU_CMP
	} alu_op_t;

	typedef enum logic [2:0] {
		IFETCH,
		DECODE,
		OFETCH,
		EXECUTE,
		MEMORY,
		MEMWAIT
	} state_t;

endpackage

`default_nettype wire
